// File: i2c_pkg.sv
package i2c_pkg;

	typedef logic [6:0] dev_addr_t;
	typedef logic [7:0] reg_addr_t;
	typedef logic [7:0] reg_data_t;

	typedef struct packed {
		dev_addr_t dev_addr;
		reg_addr_t reg_addr;
		reg_data_t data;
	} write_req_t;

	typedef enum logic [3:0] {
		M_IDLE,
		M_START,
		M_DEV_ADDR,
		M_RW,
		M_DEV_ACK,
		M_REG_ADDR,
		M_REG_ACK,
		M_WR_DATA,
		M_DATA_ACK,
		M_STOP
	} master_state_t;

	typedef enum logic [2:0] {
		T_IDLE,
		T_ADDR,
		T_ADDR_ACK,
		T_REG,
		T_REG_ACK,
		T_DATA,
		T_DATA_ACK,
		T_IGNORE
	} target_state_t;

	localparam int SCL_DIV       = 32;	// clk cycles per bus bit
	localparam int BITS_PER_XFER = 29;	// start + 3 x (8 + ack) + stop
	localparam int REG_DEPTH     = 256;

	localparam dev_addr_t TARGET_ADDR = 7'h3a;
	localparam logic      WRITE_BIT   = 1'b0;

	typedef logic [$clog2(SCL_DIV)-1:0] cnt_t;

	localparam cnt_t SCL_RISE_AT = cnt_t'(SCL_DIV / 4);
	localparam cnt_t HALF_AT     = cnt_t'(SCL_DIV / 2);	// ack sample point
	localparam cnt_t SCL_FALL_AT = cnt_t'(SCL_DIV * 3 / 4);
	localparam cnt_t BIT_END     = cnt_t'(SCL_DIV - 1);

endpackage

// File: i2c_bus_monitor.sv
`timescale 1ns/1ps

module i2c_bus_monitor (
	input  logic clk,
	input  logic rstn,
	input  logic scl,
	input  logic sda,
	output logic sda_s,
	output logic scl_rise,
	output logic scl_fall,
	output logic bus_start,
	output logic bus_stop
);

	typedef struct packed {
		logic scl;
		logic sda;
	} lines_t;

	lines_t meta;
	lines_t sync;
	lines_t prev;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			meta <= '1;	// idle bus is high
			sync <= '1;
			prev <= '1;
		end else begin
			meta <= {scl, sda};
			sync <= meta;
			prev <= sync;
		end
	end

	assign sda_s    = sync.sda;
	assign scl_rise = sync.scl & ~prev.scl;
	assign scl_fall = ~sync.scl & prev.scl;

	// sda moving while scl stays high
	assign bus_start = sync.scl & prev.scl & prev.sda & ~sync.sda;
	assign bus_stop  = sync.scl & prev.scl & ~prev.sda & sync.sda;

endmodule

// File: i2c_write_master.sv
`timescale 1ns/1ps

module i2c_write_master import i2c_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       start,
	input  write_req_t req,
	output logic       busy,
	output logic       done,
	output logic       nack,
	output logic       scl,
	output logic       sda_low,
	input  logic       sda
);

	master_state_t state;
	cnt_t          cnt;
	logic [2:0]    bit_cnt;
	write_req_t    req_q;
	reg_data_t     sh;
	logic          tx_low;
	logic          last;
	logic          ack_state;

	assign busy      = state != M_IDLE;
	assign last      = cnt == BIT_END;
	assign ack_state = state inside {M_DEV_ACK, M_REG_ACK, M_DATA_ACK};

	always_comb begin
		case (state)
			M_DEV_ADDR, M_REG_ADDR, M_WR_DATA: tx_low = ~sh[7];	// msb first
			M_RW:                              tx_low = ~WRITE_BIT;
			default:                           tx_low = 1'b0;	// released for ack
		endcase
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state   <= M_IDLE;
			cnt     <= '0;
			bit_cnt <= '0;
			scl     <= 1'b1;
			sda_low <= 1'b0;
			done    <= 1'b0;
			nack    <= 1'b0;
		end else begin
			done <= 1'b0;
			if (busy) begin
				cnt <= last ? '0 : cnt + 1'b1;
			end
			case (state)
				M_IDLE: begin
					scl     <= 1'b1;
					sda_low <= 1'b0;
					if (start) begin
						state <= M_START;
						nack  <= 1'b0;
					end
				end
				M_START: begin
					if (cnt == HALF_AT) begin
						sda_low <= 1'b1;	// start edge, scl still high
					end
					if (last) begin
						scl     <= 1'b0;
						bit_cnt <= 3'd6;
						state   <= M_DEV_ADDR;
					end
				end
				M_DEV_ADDR, M_RW, M_DEV_ACK, M_REG_ADDR, M_REG_ACK, M_WR_DATA,
				M_DATA_ACK: begin
					if (cnt == '0) begin
						sda_low <= tx_low;
					end
					if (cnt == SCL_RISE_AT) begin
						scl <= 1'b1;
					end
					if (ack_state && cnt == HALF_AT && sda) begin
						nack <= 1'b1;	// nobody pulled low
					end
					if (cnt == SCL_FALL_AT) begin
						scl <= 1'b0;
					end
					if (last) begin
						case (state)
							M_DEV_ADDR: begin
								bit_cnt <= bit_cnt - 1'b1;
								if (bit_cnt == '0) begin
									state <= M_RW;
								end
							end
							M_RW: state <= M_DEV_ACK;
							M_DEV_ACK: begin
								bit_cnt <= 3'd7;
								state   <= nack ? M_STOP : M_REG_ADDR;
							end
							M_REG_ADDR: begin
								bit_cnt <= bit_cnt - 1'b1;
								if (bit_cnt == '0) begin
									state <= M_REG_ACK;
								end
							end
							M_REG_ACK: begin
								bit_cnt <= 3'd7;
								state   <= nack ? M_STOP : M_WR_DATA;
							end
							M_WR_DATA: begin
								bit_cnt <= bit_cnt - 1'b1;
								if (bit_cnt == '0) begin
									state <= M_DATA_ACK;
								end
							end
							default: state <= M_STOP;	// data ack, either way
						endcase
					end
				end
				M_STOP: begin
					if (cnt == '0) begin
						sda_low <= 1'b1;
					end
					if (cnt == SCL_RISE_AT) begin
						scl <= 1'b1;
					end
					if (cnt == HALF_AT) begin
						sda_low <= 1'b0;	// stop edge
					end
					if (last) begin
						state <= M_IDLE;
						done  <= 1'b1;
					end
				end
				default: state <= M_IDLE;
			endcase
		end
	end

	// request copy and outgoing byte
	always_ff @(posedge clk) begin
		if (state == M_IDLE && start) begin
			req_q <= req;
		end
		if (last) begin
			case (state)
				M_START:   sh <= {req_q.dev_addr, WRITE_BIT};
				M_DEV_ACK: sh <= req_q.reg_addr;
				M_REG_ACK: sh <= req_q.data;
				default:   sh <= {sh[6:0], 1'b0};
			endcase
		end
	end

endmodule

// File: i2c_reg_target.sv
`timescale 1ns/1ps

module i2c_reg_target import i2c_pkg::*; (
	input  logic      clk,
	input  logic      rstn,
	input  logic      sda_s,
	input  logic      scl_rise,
	input  logic      scl_fall,
	input  logic      bus_start,
	input  logic      bus_stop,
	output logic      sda_low,
	input  reg_addr_t rd_addr,
	output reg_data_t rd_data
);

	target_state_t state;
	logic [3:0]    bit_cnt;
	reg_data_t     shift;
	reg_addr_t     reg_q;
	reg_addr_t     rd_addr_q;
	reg_data_t     regs [REG_DEPTH];
	logic          rx_state;
	logic          bit_in;
	logic          byte_end;
	logic          addr_hit;
	logic          wr_en;

	assign rx_state = state inside {T_ADDR, T_REG, T_DATA};
	assign bit_in   = rx_state && scl_rise && bit_cnt != 4'd8;
	assign byte_end = rx_state && scl_fall && bit_cnt == 4'd8;	// fall after 8th bit
	assign addr_hit = shift == {TARGET_ADDR, WRITE_BIT};
	assign wr_en    = byte_end && state == T_DATA;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state   <= T_IDLE;
			bit_cnt <= '0;
			sda_low <= 1'b0;
		end else if (bus_start) begin
			state   <= T_ADDR;
			bit_cnt <= '0;
			sda_low <= 1'b0;
		end else if (bus_stop) begin
			state   <= T_IDLE;
			bit_cnt <= '0;
			sda_low <= 1'b0;
		end else begin
			case (state)
				T_ADDR, T_REG, T_DATA: begin
					if (bit_in) begin
						bit_cnt <= bit_cnt + 1'b1;
					end
					if (byte_end) begin
						bit_cnt <= '0;
						if (state == T_ADDR && !addr_hit) begin
							state <= T_IGNORE;	// not us, or a read
						end else begin
							sda_low <= 1'b1;
							case (state)
								T_ADDR:  state <= T_ADDR_ACK;
								T_REG:   state <= T_REG_ACK;
								default: state <= T_DATA_ACK;
							endcase
						end
					end
				end
				T_ADDR_ACK, T_REG_ACK, T_DATA_ACK: begin
					if (scl_fall) begin
						sda_low <= 1'b0;	// end of ack bit
						case (state)
							T_ADDR_ACK: state <= T_REG;
							T_REG_ACK:  state <= T_DATA;
							default:    state <= T_IDLE;	// wait for stop
						endcase
					end
				end
				default: state <= state;	// idle and ignore wait for bus events
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (bit_in) begin
			shift <= {shift[6:0], sda_s};
		end
		if (byte_end && state == T_REG) begin
			reg_q <= shift;
		end
		rd_addr_q <= rd_addr;
		rd_data   <= regs[rd_addr_q];
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			for (int i = 0; i < REG_DEPTH; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_en) begin
			regs[reg_q] <= shift;
		end
	end

endmodule

// File: i2c_write_top.sv
`timescale 1ns/1ps

module i2c_write_top import i2c_pkg::*; (
	input  logic       clk,
	input  logic       rstn,
	input  logic       start,
	input  write_req_t req,
	output logic       busy,
	output logic       done,
	output logic       nack,
	input  reg_addr_t  rd_addr,
	output reg_data_t  rd_data,
	output logic       scl,
	output logic       sda
);

	logic sda_low_m;
	logic sda_low_t;
	logic sda_s;
	logic scl_rise;
	logic scl_fall;
	logic bus_start;
	logic bus_stop;

	assign sda = ~(sda_low_m | sda_low_t);	// wired-and, pulled up when released

	i2c_write_master u_master (
		.clk     (clk),
		.rstn    (rstn),
		.start   (start),
		.req     (req),
		.busy    (busy),
		.done    (done),
		.nack    (nack),
		.scl     (scl),
		.sda_low (sda_low_m),
		.sda     (sda)
	);

	i2c_bus_monitor u_monitor (
		.clk       (clk),
		.rstn      (rstn),
		.scl       (scl),
		.sda       (sda),
		.sda_s     (sda_s),
		.scl_rise  (scl_rise),
		.scl_fall  (scl_fall),
		.bus_start (bus_start),
		.bus_stop  (bus_stop)
	);

	i2c_reg_target u_target (
		.clk       (clk),
		.rstn      (rstn),
		.sda_s     (sda_s),
		.scl_rise  (scl_rise),
		.scl_fall  (scl_fall),
		.bus_start (bus_start),
		.bus_stop  (bus_stop),
		.sda_low   (sda_low_t),
		.rd_addr   (rd_addr),
		.rd_data   (rd_data)
	);

endmodule

// File: tb_i2c_write.sv
`timescale 1ns/1ps

module tb_i2c_write import i2c_pkg::*; ();

	localparam int     CLK_NS    = 40;
	localparam int     NSTEPS    = 10;
	localparam int     LEN_ACK   = BITS_PER_XFER * SCL_DIV;
	localparam int     LEN_NACK  = 11 * SCL_DIV;	// start, 8 bits, ack, stop
	localparam int     POKE_AT   = 5 * SCL_DIV;
	localparam int     WD_FACTOR = 2;
	localparam longint WD_NS     = longint'(NSTEPS + 4) * BITS_PER_XFER * SCL_DIV * CLK_NS
		* WD_FACTOR;
	localparam logic [31:0] SEED = 32'hbd479eeb;

	typedef struct packed {
		write_req_t req;
		logic       rnd;	// data byte from the lfsr
		logic       poke;	// extra start while busy
		logic       exp_nack;
		int         exp_len;
	} step_t;

	logic        clk = 1'b0;
	logic        rstn;
	logic        start;
	write_req_t  req;
	logic        busy;
	logic        done;
	logic        nack;
	reg_addr_t   rd_addr;
	reg_data_t   rd_data;
	logic        scl;
	logic        sda;

	step_t       steps [NSTEPS];
	reg_data_t   shadow [REG_DEPTH];
	logic [31:0] lfsr;
	int          errors = 0;
	int          busy_cycles = 0;
	int          done_pulses = 0;
	int          sda_falls_hi = 0;
	int          sda_rises_hi = 0;
	logic        busy_at_done = 1'b0;
	logic        busy_before_done = 1'b0;
	logic        busy_q = 1'b0;
	logic        scl_q = 1'b1;
	logic        sda_q = 1'b1;

	i2c_write_top dut0 (
		.clk     (clk),
		.rstn    (rstn),
		.start   (start),
		.req     (req),
		.busy    (busy),
		.done    (done),
		.nack    (nack),
		.rd_addr (rd_addr),
		.rd_data (rd_data),
		.scl     (scl),
		.sda     (sda)
	);

	always #(CLK_NS / 2) clk = ~clk;

	// bus activity sampled away from the driving edge
	always @(negedge clk) begin
		if (busy) begin
			busy_cycles++;
		end
		if (done) begin
			done_pulses++;
			busy_at_done     = busy;
			busy_before_done = busy_q;
		end
		if ((scl || scl_q) && sda != sda_q) begin
			if (sda) begin
				sda_rises_hi++;	// stop edge
			end else begin
				sda_falls_hi++;	// start edge
			end
		end
		busy_q = busy;
		scl_q  = scl;
		sda_q  = sda;
	end

	initial begin
		#(WD_NS);
		$display("watchdog expired before the tests finished");
		$display("SOME TESTS FAILED");
		$finish;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'ha3000000) : (s >> 1);
	endfunction

	task automatic next_byte(output reg_data_t b);
		for (int k = 0; k < 8; k++) begin
			b    = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic step_t entry(input dev_addr_t dev, input reg_addr_t ra,
		input reg_data_t d, input logic rnd, input logic poke, input logic exp_nack);
		step_t s;
		s.req.dev_addr = dev;
		s.req.reg_addr = ra;
		s.req.data     = d;
		s.rnd          = rnd;
		s.poke         = poke;
		s.exp_nack     = exp_nack;
		s.exp_len      = exp_nack ? LEN_NACK : LEN_ACK;
		return s;
	endfunction

	task automatic load_table();
		steps[0] = entry(TARGET_ADDR, 8'h10, 8'ha5, 1'b0, 1'b0, 1'b0);
		steps[1] = entry(7'h3b,       8'h10, 8'hff, 1'b0, 1'b0, 1'b1);
		steps[2] = entry(TARGET_ADDR, 8'h20, 8'h00, 1'b1, 1'b1, 1'b0);
		steps[3] = entry(TARGET_ADDR, 8'h21, 8'h00, 1'b1, 1'b0, 1'b0);
		steps[4] = entry(TARGET_ADDR, 8'h20, 8'h00, 1'b1, 1'b0, 1'b0);	// overwrite
		steps[5] = entry(7'h00,       8'h21, 8'h77, 1'b0, 1'b0, 1'b1);
		steps[6] = entry(TARGET_ADDR, 8'hff, 8'h00, 1'b1, 1'b0, 1'b0);
		steps[7] = entry(TARGET_ADDR, 8'h00, 8'h00, 1'b1, 1'b0, 1'b0);
		steps[8] = entry(7'h7a,       8'h00, 8'h13, 1'b0, 1'b0, 1'b1);
		steps[9] = entry(TARGET_ADDR, 8'h21, 8'h00, 1'b1, 1'b1, 1'b0);
	endtask

	task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			$display("ERR %0t %s expected %b got %b", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic check_count(input string name, input int exp, input int act);
		if (act != exp) begin
			$display("ERR %0t %s expected %0d got %0d", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic read_reg(input reg_addr_t a, output reg_data_t d);
		@(posedge clk);
		#2 rd_addr = a;
		repeat (2) @(posedge clk);	// address register, then data register
		@(negedge clk);
		d = rd_data;
	endtask

	task automatic wait_done(input int idx);
		int n;
		n = 0;
		while (done !== 1'b1 && n < 2 * LEN_ACK) begin
			@(negedge clk);
			n++;
		end
		if (done !== 1'b1) begin
			$display("step %0d never finished, no done pulse after %0d cycles", idx, n);
			errors++;
		end
	endtask

	initial begin
		step_t     s;
		reg_data_t d;
		int        b0;
		int        p0;
		int        f0;
		int        r0;
		rstn    = 1'b0;
		start   = 1'b0;
		req     = '0;
		rd_addr = '0;
		lfsr    = SEED;
		for (int a = 0; a < REG_DEPTH; a++) begin
			shadow[a] = '0;
		end
		load_table();
		repeat (4) @(posedge clk);
		#2 rstn = 1'b1;

		@(negedge clk);
		check_flag("busy", 1'b0, busy);
		check_flag("done", 1'b0, done);
		check_flag("nack", 1'b0, nack);
		check_flag("scl", 1'b1, scl);
		check_flag("sda", 1'b1, sda);
		foreach (steps[i]) begin
			read_reg(steps[i].req.reg_addr, d);
			check_data("rd_data", 8'h00, d);
		end

		for (int i = 0; i < NSTEPS; i++) begin
			s = steps[i];
			if (s.rnd) begin
				next_byte(d);
				s.req.data = d;
			end
			b0 = busy_cycles;
			p0 = done_pulses;
			f0 = sda_falls_hi;
			r0 = sda_rises_hi;
			@(posedge clk);
			#2;
			req   = s.req;
			start = 1'b1;
			@(posedge clk);
			#2 start = 1'b0;
			if (s.poke) begin
				repeat (POKE_AT) @(posedge clk);
				#2 start = 1'b1;	// must be ignored
				@(posedge clk);
				#2 start = 1'b0;
			end
			wait_done(i);
			repeat (4) @(negedge clk);
			check_count("busy_cycles", s.exp_len, busy_cycles - b0);
			check_count("done_pulses", 1, done_pulses - p0);
			check_flag("busy_at_done", 1'b0, busy_at_done);
			check_flag("busy_before_done", 1'b1, busy_before_done);
			check_flag("busy", 1'b0, busy);
			check_flag("nack", s.exp_nack, nack);
			check_count("sda_falls_scl_high", 1, sda_falls_hi - f0);
			check_count("sda_rises_scl_high", 1, sda_rises_hi - r0);
			if (!s.exp_nack) begin
				shadow[s.req.reg_addr] = s.req.data;
			end
			read_reg(s.req.reg_addr, d);
			check_data("rd_data", shadow[s.req.reg_addr], d);
		end

		for (int a = 0; a < REG_DEPTH; a++) begin
			read_reg(reg_addr_t'(a), d);
			check_data("rd_data", shadow[a], d);
		end

		$display("%0d errors in %0d steps", errors, NSTEPS);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: vlog.f
i2c_pkg.sv
i2c_bus_monitor.sv
i2c_write_master.sv
i2c_reg_target.sv
i2c_write_top.sv
tb_i2c_write.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_i2c_write
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -Wno-fatal
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
